/* rtl/bpcPkg.sv */
package bpcPkg;

  // Word address slice of a 32-bit byte address
  localparam int ADDR_HI = 31;
  localparam int ADDR_LO = 2;

  // Unconditional branches, with and without the immediate form
  localparam logic [5:0] OPC_BRU_A = 6'o46;
  localparam logic [5:0] OPC_BRU_B = 6'o56;

  // Conditional branches
  localparam logic [5:0] OPC_BCC_A = 6'o47;
  localparam logic [5:0] OPC_BCC_B = 6'o57;

  // Prefix and return, both unsafe as interrupt points
  localparam logic [5:0] OPC_IMM = 6'o54;
  localparam logic [5:0] OPC_RTD = 6'o55;

  // Branch conditions, rd[2:0] of a BCC word
  localparam logic [2:0] CC_EQ = 3'd0;
  localparam logic [2:0] CC_NE = 3'd1;
  localparam logic [2:0] CC_LT = 3'd2;
  localparam logic [2:0] CC_LE = 3'd3;
  localparam logic [2:0] CC_GT = 3'd4;
  localparam logic [2:0] CC_GE = 3'd5;

  // Compare operand source
  localparam logic [1:0] FWD_REG  = 2'd0;
  localparam logic [1:0] FWD_ALU  = 2'd1;
  localparam logic [1:0] FWD_LOAD = 2'd2;

  // Outstanding fetches accepted by the instruction memory
  localparam int CREDIT_MAX = 4;
  // Wide enough to hold CREDIT_MAX itself
  localparam int CREDIT_W = 3;

endpackage

/* rtl/branchDecode.sv */
module branchDecode (
  input  logic        gclk,
  input  logic        grst,
  input  logic        dEn,
  input  logic [31:0] instrWord,
  output logic        isBcc,
  output logic        isBru,
  output logic [2:0]  condCode,
  output logic        delayed
);

  logic [5:0] opcode;
  logic [4:0] rd;
  logic [4:0] ra;
  logic       bccOp;
  logic       bruOp;

  // Field split, opcode in the top bits
  assign opcode = instrWord[31:26];
  assign rd     = instrWord[25:21];
  assign ra     = instrWord[20:16];

  assign bccOp = (opcode == bpcPkg::OPC_BCC_A) || (opcode == bpcPkg::OPC_BCC_B);
  assign bruOp = (opcode == bpcPkg::OPC_BRU_A) || (opcode == bpcPkg::OPC_BRU_B);

  always_ff @(posedge gclk) begin
    if (grst) begin
      isBcc    <= 1'b0;
      isBru    <= 1'b0;
      condCode <= bpcPkg::CC_EQ;
      delayed  <= 1'b0;
    end else if (dEn) begin
      isBcc    <= bccOp;
      isBru    <= bruOp;
      condCode <= rd[2:0];
      // Delay bit sits in rd for BCC but in ra for BRU
      delayed  <= (bruOp && ra[4]) || (bccOp && rd[4]);
    end
  end

  // One branch kind at a time, held across decode enables
  assert property (@(posedge gclk) disable iff (grst) !(isBcc && isBru))
    else $error("branchDecode: BCC and BRU flags both set");

endmodule

/* rtl/branchEval.sv */
module branchEval (
  input  logic [1:0]  fwdSel,
  input  logic [31:0] regA,
  input  logic [31:0] aluResult,
  input  logic [31:0] loadData,
  input  logic        isBcc,
  input  logic        isBru,
  input  logic [2:0]  condCode,
  output logic        branchTaken
);

  logic [31:0] operand;
  logic        isZero;
  logic        isNeg;
  logic        condMet;

  // Forwarding mux, register file value unless a newer one is in flight
  always_comb begin
    case (fwdSel)
      bpcPkg::FWD_ALU:  operand = aluResult;
      bpcPkg::FWD_LOAD: operand = loadData;
      default:          operand = regA;
    endcase
  end

  assign isZero = (operand == 32'd0);
  assign isNeg  = operand[31];

  // Signed compare against zero
  always_comb begin
    case (condCode)
      bpcPkg::CC_EQ: condMet = isZero;
      bpcPkg::CC_NE: condMet = !isZero;
      bpcPkg::CC_LT: condMet = isNeg;
      bpcPkg::CC_LE: condMet = isZero || isNeg;
      bpcPkg::CC_GT: condMet = !isZero && !isNeg;
      bpcPkg::CC_GE: condMet = !isNeg;
      default:       condMet = 1'b0;
    endcase
  end

  assign branchTaken = isBru || (isBcc && condMet);

  // Selector value 3 has no source behind it
  always_comb begin
    assert ($isunknown(fwdSel) ||
            (fwdSel inside {bpcPkg::FWD_REG, bpcPkg::FWD_ALU, bpcPkg::FWD_LOAD}))
      else $error("branchEval: illegal forwarding select %0d", fwdSel);
  end

endmodule

/* rtl/pcPipeline.sv */
module pcPipeline (
  input  logic                                 gclk,
  input  logic                                 grst,
  input  logic                                 stepEn,
  input  logic                                 branchTaken,
  input  logic                                 delayed,
  input  logic [bpcPkg::ADDR_HI:bpcPkg::ADDR_LO] target,
  input  logic                                 memopStep,
  input  logic [5:0]                           opcode,
  output logic [bpcPkg::ADDR_HI:bpcPkg::ADDR_LO] nextFetch,
  output logic [bpcPkg::ADDR_HI:bpcPkg::ADDR_LO] pc,
  output logic [bpcPkg::ADDR_HI:bpcPkg::ADDR_LO] pcLink,
  output logic                                 dSkip,
  output logic                                 xSkip,
  output logic [1:0]                           atomBorder
);

  logic [bpcPkg::ADDR_HI:bpcPkg::ADDR_LO] preFetch;
  logic [bpcPkg::ADDR_HI:bpcPkg::ADDR_LO] pcIncr;
  logic                                 firstSkip;
  logic                                 rSkip;
  logic                                 isBranchOp;
  logic                                 unsafeOp;
  logic                                 safeBorder;

  // Word step is zero or one
  assign pcIncr = {{(bpcPkg::ADDR_HI - bpcPkg::ADDR_LO){1'b0}}, memopStep};

  assign nextFetch = branchTaken ? target : (preFetch + pcIncr);

  // Taken branch without delay slot squashes what follows
  assign firstSkip = branchTaken && !delayed;
  assign dSkip     = firstSkip || rSkip;

  assign isBranchOp = (opcode == bpcPkg::OPC_BRU_A) || (opcode == bpcPkg::OPC_BRU_B) ||
                      (opcode == bpcPkg::OPC_BCC_A) || (opcode == bpcPkg::OPC_BCC_B);
  assign unsafeOp   = isBranchOp || (opcode == bpcPkg::OPC_IMM) ||
                      (opcode == bpcPkg::OPC_RTD);

  // A squashed instruction never splits an atomic sequence
  assign safeBorder = !(unsafeOp && !firstSkip);

  always_ff @(posedge gclk) begin
    if (grst) begin
      preFetch   <= '0;
      pc         <= '0;
      pcLink     <= '0;
      rSkip      <= 1'b0;
      xSkip      <= 1'b0;
      atomBorder <= 2'b00;
    end else if (stepEn) begin
      preFetch   <= nextFetch;
      pc         <= preFetch;
      pcLink     <= pc;
      rSkip      <= firstSkip;
      xSkip      <= dSkip;
      // Shift in old low bit XOR safe
      atomBorder <= {atomBorder[0], atomBorder[0] ^ safeBorder};
    end
  end

endmodule

/* rtl/fetchCredit.sv */
module fetchCredit (
  input  logic gclk,
  input  logic grst,
  input  logic advance,
  input  logic creditReturn,
  output logic stepEn,
  output logic fetchValid
);

  logic [bpcPkg::CREDIT_W-1:0] creditCount;
  logic                        haveCredit;

  assign haveCredit = (creditCount != '0);

  // Pipeline moves only when memory can take another fetch
  assign stepEn     = advance && haveCredit;
  assign fetchValid = stepEn;

  always_ff @(posedge gclk) begin
    if (grst) begin
      creditCount <= bpcPkg::CREDIT_W'(bpcPkg::CREDIT_MAX);
    end else begin
      case ({stepEn, creditReturn})
        2'b10:   creditCount <= creditCount - 1'b1;
        2'b01:   creditCount <= creditCount + 1'b1;
        // Spend and return together cancel out
        default: creditCount <= creditCount;
      endcase
    end
  end

  // Upper bound across any mix of spends and returns
  assert property (@(posedge gclk) disable iff (grst)
                   creditCount <= bpcPkg::CREDIT_W'(bpcPkg::CREDIT_MAX))
    else $error("fetchCredit: credit count %0d above limit", creditCount);

  // Memory returns only credits that were spent
  assert property (@(posedge gclk) disable iff (grst)
                   creditReturn |-> creditCount != bpcPkg::CREDIT_W'(bpcPkg::CREDIT_MAX))
    else $error("fetchCredit: credit returned with none outstanding");

endmodule

/* rtl/branchUnit.sv */
module branchUnit (
  input  logic                                 gclk,
  input  logic                                 grst,
  input  logic                                 advance,
  input  logic                                 dEn,
  input  logic [31:0]                          instrWord,
  input  logic [1:0]                           fwdSel,
  input  logic [31:0]                          regA,
  input  logic [31:0]                          aluResult,
  input  logic [31:0]                          loadData,
  input  logic [31:0]                          xResult,
  input  logic                                 memopStep,
  input  logic                                 creditReturn,
  output logic [bpcPkg::ADDR_HI:bpcPkg::ADDR_LO] fetchAddr,
  output logic                                 fetchValid,
  output logic [bpcPkg::ADDR_HI:bpcPkg::ADDR_LO] pc,
  output logic [bpcPkg::ADDR_HI:bpcPkg::ADDR_LO] pcLink,
  output logic                                 dSkip,
  output logic                                 xSkip,
  output logic [1:0]                           atomBorder
);

  logic       isBcc;
  logic       isBru;
  logic [2:0] condCode;
  logic       delayed;
  logic       branchTaken;
  logic       stepEn;

  branchDecode decode (
    .gclk      (gclk),
    .grst      (grst),
    .dEn       (dEn),
    .instrWord (instrWord),
    .isBcc     (isBcc),
    .isBru     (isBru),
    .condCode  (condCode),
    .delayed   (delayed)
  );

  branchEval eval (
    .fwdSel      (fwdSel),
    .regA        (regA),
    .aluResult   (aluResult),
    .loadData    (loadData),
    .isBcc       (isBcc),
    .isBru       (isBru),
    .condCode    (condCode),
    .branchTaken (branchTaken)
  );

  // Branch target is the word part of the ALU result
  pcPipeline pcPipe (
    .gclk        (gclk),
    .grst        (grst),
    .stepEn      (stepEn),
    .branchTaken (branchTaken),
    .delayed     (delayed),
    .target      (xResult[bpcPkg::ADDR_HI:bpcPkg::ADDR_LO]),
    .memopStep   (memopStep),
    .opcode      (instrWord[31:26]),
    .nextFetch   (fetchAddr),
    .pc          (pc),
    .pcLink      (pcLink),
    .dSkip       (dSkip),
    .xSkip       (xSkip),
    .atomBorder  (atomBorder)
  );

  fetchCredit credit (
    .gclk         (gclk),
    .grst         (grst),
    .advance      (advance),
    .creditReturn (creditReturn),
    .stepEn       (stepEn),
    .fetchValid   (fetchValid)
  );

endmodule

/* verif/branchUnitTb.sv */
module branchUnitTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  localparam logic [15:0] LFSR_SEED = 16'd29511;

  // Condition outcome per operand kind as bits {negative, positive, zero}
  localparam logic [2:0] COND_TRUTH [0:5] = '{3'b001, 3'b110, 3'b100, 3'b101, 3'b010, 3'b011};
  localparam logic [31:0] OPERANDS [0:2] = '{32'd0, 32'd5, 32'hFFFF_FFF0};

  typedef struct packed {
    logic [31:0] instr;
    logic [1:0]  fwd;
    logic [31:0] regA;
    logic [31:0] alu;
    logic [31:0] load;
    logic [31:0] xRes;
    logic        step;
    logic        adv;
    logic        hold;
    logic        expTaken;
  } rowT;

  logic        gclk;
  logic        grst;
  logic        advance;
  logic        dEn;
  logic [31:0] instrWord;
  logic [1:0]  fwdSel;
  logic [31:0] regA;
  logic [31:0] aluResult;
  logic [31:0] loadData;
  logic [31:0] xResult;
  logic        memopStep;
  logic        creditReturn;
  logic [29:0] fetchAddr;
  logic        fetchValid;
  logic [29:0] pc;
  logic [29:0] pcLink;
  logic        dSkip;
  logic        xSkip;
  logic [1:0]  atomBorder;

  rowT   rows[$];
  string rowNames[$];
  int    rowCount;
  bit    tableReady;
  int    errors;
  int    checks;
  int    rowErrors;
  logic [15:0] lfsr;
  int    cycleNum;
  int    dueCycles[$];
  int    fetches;
  int    returns;
  int    stallCycles;

  // Reference state
  logic [29:0] mPre;
  logic [29:0] mPc;
  logic [29:0] mLink;
  logic        mRSkip;
  logic        mXSkip;
  logic [1:0]  mAtom;
  int          mCredits;

  branchUnit dut_i (
    .gclk         (gclk),
    .grst         (grst),
    .advance      (advance),
    .dEn          (dEn),
    .instrWord    (instrWord),
    .fwdSel       (fwdSel),
    .regA         (regA),
    .aluResult    (aluResult),
    .loadData     (loadData),
    .xResult      (xResult),
    .memopStep    (memopStep),
    .creditReturn (creditReturn),
    .fetchAddr    (fetchAddr),
    .fetchValid   (fetchValid),
    .pc           (pc),
    .pcLink       (pcLink),
    .dSkip        (dSkip),
    .xSkip        (xSkip),
    .atomBorder   (atomBorder)
  );

  initial gclk = 1'b0;
  always #5 gclk = ~gclk;

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // rd holds {delay, 0, cond}
  function automatic logic [31:0] bccWord(input logic [2:0] cond, input logic delay);
    return {bpcPkg::OPC_BCC_A, delay, 1'b0, cond, 21'd0};
  endfunction

  // Delay bit is ra[4] for BRU
  function automatic logic [31:0] bruWord(input logic delay);
    return {bpcPkg::OPC_BRU_A, 5'd0, delay, 4'd0, 16'd0};
  endfunction

  function automatic logic [31:0] plainWord(input logic [5:0] opc);
    return {opc, 26'd0};
  endfunction

  function automatic logic delayBit(input logic [31:0] word);
    if (word[31:26] == bpcPkg::OPC_BCC_A || word[31:26] == bpcPkg::OPC_BCC_B) begin
      return word[25];
    end
    if (word[31:26] == bpcPkg::OPC_BRU_A || word[31:26] == bpcPkg::OPC_BRU_B) begin
      return word[20];
    end
    return 1'b0;
  endfunction

  function automatic logic isUnsafe(input logic [5:0] opc);
    return opc == bpcPkg::OPC_BCC_A || opc == bpcPkg::OPC_BCC_B ||
           opc == bpcPkg::OPC_BRU_A || opc == bpcPkg::OPC_BRU_B ||
           opc == bpcPkg::OPC_IMM || opc == bpcPkg::OPC_RTD;
  endfunction

  task automatic addRow(input string name, input logic [31:0] instr, input logic [1:0] fwd,
                        input logic [31:0] a, input logic [31:0] alu, input logic [31:0] ld,
                        input logic [31:0] xr, input logic step, input logic adv,
                        input logic hold, input logic taken);
    rows.push_back('{instr, fwd, a, alu, ld, xr, step, adv, hold, taken});
    rowNames.push_back(name);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      rowErrors++;
    end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Error at %0t ns: %s", $time, what);
      rowErrors++;
    end
  endtask

  task automatic buildTable();
    int c;
    int k;
    int f;
    for (c = 0; c < 6; c++) begin
      for (k = 0; k < 3; k++) begin
        addRow("bcc condition", bccWord(3'(c), k == 1), bpcPkg::FWD_REG, OPERANDS[k],
               32'd7, 32'd9, 32'h0001_0000 + (32'(c * 3 + k) << 8), k != 2, 1'b1, 1'b0,
               COND_TRUTH[c][k]);
      end
    end
    // Only the selected source is zero, then only the selected source is nonzero
    for (f = 0; f < 3; f++) begin
      addRow("forward zero", bccWord(bpcPkg::CC_EQ, 1'b0), 2'(f), (f == 0) ? 32'd0 : 32'd3,
             (f == 1) ? 32'd0 : 32'd3, (f == 2) ? 32'd0 : 32'd3,
             32'h0002_0000 + (32'(f) << 8), 1'b1, 1'b1, 1'b0, 1'b1);
      addRow("forward nonzero", bccWord(bpcPkg::CC_EQ, 1'b0), 2'(f), (f == 0) ? 32'd3 : 32'd0,
             (f == 1) ? 32'd3 : 32'd0, (f == 2) ? 32'd3 : 32'd0,
             32'h0003_0000, 1'b1, 1'b1, 1'b0, 1'b0);
    end
    addRow("bru no delay", bruWord(1'b0), 2'd0, 0, 0, 0, 32'h0004_0000, 1'b1, 1'b1, 1'b0, 1'b1);
    addRow("after bru", plainWord(6'o00), 2'd0, 0, 0, 0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
    addRow("plain", plainWord(6'o00), 2'd0, 0, 0, 0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
    addRow("bru delay", bruWord(1'b1), 2'd0, 0, 0, 0, 32'h0005_0000, 1'b1, 1'b1, 1'b0, 1'b1);
    addRow("plain", plainWord(6'o01), 2'd0, 0, 0, 0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
    addRow("imm prefix", plainWord(bpcPkg::OPC_IMM), 2'd0, 0, 0, 0, 32'h0, 1'b1, 1'b1, 1'b0,
           1'b0);
    addRow("rtd", plainWord(bpcPkg::OPC_RTD), 2'd0, 0, 0, 0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
    addRow("bcc ne delay", bccWord(bpcPkg::CC_NE, 1'b1), 2'd0, 32'd5, 0, 0, 32'h0006_0000,
           1'b1, 1'b1, 1'b0, 1'b1);
    addRow("plain step 0", plainWord(6'o00), 2'd0, 0, 0, 0, 32'h0, 1'b0, 1'b1, 1'b0, 1'b0);
    addRow("no advance", plainWord(6'o00), 2'd0, 0, 0, 0, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0);
    // Returns withheld, then released
    for (k = 0; k < 10; k++) begin
      addRow(k < 6 ? "credit hold" : "credit resume", plainWord(6'o00), 2'd0, 0, 0, 0, 32'h0,
             1'b1, 1'b1, k < 6, 1'b0);
    end
  endtask

  task automatic runCycle(input rowT r, input logic decode);
    int idx;
    int delay;
    logic expStep;
    logic dly;
    logic firstSkip;
    logic safe;
    logic [29:0] expFetch;
    @(negedge gclk);
    // Memory model gives back the oldest due credit each cycle
    creditReturn = 1'b0;
    idx = -1;
    if (!r.hold) begin
      foreach (dueCycles[i]) begin
        if (idx < 0 && dueCycles[i] <= cycleNum) idx = i;
      end
    end
    if (idx >= 0) begin
      creditReturn = 1'b1;
      dueCycles.delete(idx);
    end
    instrWord = r.instr;
    dEn       = decode;
    advance   = decode ? 1'b0 : r.adv;
    fwdSel    = r.fwd;
    regA      = r.regA;
    aluResult = r.alu;
    loadData  = r.load;
    xResult   = r.xRes;
    memopStep = r.step;
    #1;
    dly       = delayBit(r.instr);
    firstSkip = r.expTaken && !dly;
    expFetch  = r.expTaken ? r.xRes[31:2] : mPre + 30'(r.step);
    expStep   = advance && (mCredits > 0);
    checkValue("fetchValid", 32'(fetchValid), 32'(expStep));
    checkValue("pc", 32'(pc), 32'(mPc));
    checkValue("pcLink", 32'(pcLink), 32'(mLink));
    checkValue("xSkip", 32'(xSkip), 32'(mXSkip));
    checkValue("atomBorder", 32'(atomBorder), 32'(mAtom));
    if (!decode) begin
      checkValue("fetchAddr", 32'(fetchAddr), 32'(expFetch));
      checkValue("dSkip", 32'(dSkip), 32'(firstSkip || mRSkip));
    end
    if (advance && !fetchValid) stallCycles++;
    if (fetchValid) begin
      fetches++;
      lfsr  = lfsrNext(lfsr);
      delay = 1 + int'(lfsr[0]);
      lfsr  = lfsrNext(lfsr);
      delay = delay + int'(lfsr[0]);
      dueCycles.push_back(cycleNum + delay);
    end
    if (creditReturn) returns++;
    checkTrue(fetches <= returns + bpcPkg::CREDIT_MAX, "more fetches issued than credits allow");
    if (expStep) begin
      safe   = !(isUnsafe(r.instr[31:26]) && !firstSkip);
      mLink  = mPc;
      mPc    = mPre;
      mPre   = expFetch;
      mXSkip = firstSkip || mRSkip;
      mRSkip = firstSkip;
      mAtom  = {mAtom[0], mAtom[0] ^ safe};
    end
    mCredits = mCredits + int'(creditReturn) - int'(expStep);
    cycleNum++;
  endtask

  initial begin
    grst = 1'b1;
    advance = 1'b0;
    dEn = 1'b0;
    instrWord = '0;
    fwdSel = bpcPkg::FWD_REG;
    regA = '0;
    aluResult = '0;
    loadData = '0;
    xResult = '0;
    memopStep = 1'b0;
    creditReturn = 1'b0;
    lfsr = LFSR_SEED;
    mPre = '0;
    mPc = '0;
    mLink = '0;
    mRSkip = 1'b0;
    mXSkip = 1'b0;
    mAtom = 2'b00;
    mCredits = bpcPkg::CREDIT_MAX;
    buildTable();
    rowCount = rows.size();
    tableReady = 1'b1;
    repeat (RESET_CYCLES) @(posedge gclk);
    @(negedge gclk);
    grst = 1'b0;
    #1;
    rowErrors = 0;
    checkValue("fetchValid", 32'(fetchValid), 32'd0);
    checkValue("pc", 32'(pc), 32'd0);
    checkValue("pcLink", 32'(pcLink), 32'd0);
    checkValue("fetchAddr", 32'(fetchAddr), 32'd0);
    checkValue("dSkip", 32'(dSkip), 32'd0);
    checkValue("xSkip", 32'(xSkip), 32'd0);
    errors += rowErrors;
    $display("reset state: %s", rowErrors == 0 ? "ok" : "failed");
    for (int n = 0; n < rowCount; n++) begin
      rowErrors = 0;
      runCycle(rows[n], 1'b1);
      runCycle(rows[n], 1'b0);
      errors += rowErrors;
      $display("row %0d %s: %s", n, rowNames[n], rowErrors == 0 ? "ok" : "failed");
    end
    rowErrors = 0;
    checkTrue(stallCycles > 0, "fetch never stalled while credits were withheld");
    errors += rowErrors;
    $display("Done: %0d rows, %0d checks, %0d errors, %0d fetches, %0d returns",
             rowCount, checks, errors, fetches, returns);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog scaled to the table length
  initial begin
    wait (tableReady);
    repeat (rowCount * 20 + RESET_CYCLES) @(posedge gclk);
    $display("Timeout: run did not finish within %0d cycles", rowCount * 20 + RESET_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* branchUnit.f */
rtl/bpcPkg.sv
rtl/branchDecode.sv
rtl/branchEval.sv
rtl/pcPipeline.sv
rtl/fetchCredit.sv
rtl/branchUnit.sv
verif/branchUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f branchUnit.f --top-module branchUnitTb -o branchUnitSim \
  && ./obj_dir/branchUnitSim | tee /dev/stderr | grep -q "TEST PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
